//--- rtl/uni_lite_arbiter.sv
`include "uni_lite_defines.svh"

module uni_lite_arbiter
  (input clk_i
  , input reset_i

  , input [`UL_NUM_REQ-1:0] req_v_i
  , input uni_lite_pkg::mem_op_e [`UL_NUM_REQ-1:0] req_op_i
  , input [`UL_NUM_REQ-1:0][`UL_PADDR_WIDTH-1:0] req_addr_i
  , input [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] req_data_i
  , output logic [`UL_NUM_REQ-1:0] req_ready_o

  , output logic [`UL_NUM_REQ-1:0] resp_v_o
  , output logic [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] resp_data_o
  , input [`UL_NUM_REQ-1:0] resp_ready_i

  , output logic cmd_v_o
  , output uni_lite_pkg::mem_op_e cmd_op_o
  , output logic [`UL_PADDR_WIDTH-1:0] cmd_addr_o
  , output logic [`UL_DATA_WIDTH-1:0] cmd_data_o
  , input cmd_ready_i

  , input rsp_v_i
  , input [`UL_DATA_WIDTH-1:0] rsp_data_i
  , output logic rsp_ready_o
  );

  import uni_lite_pkg::*;

  localparam int req_id_width_lp = $clog2(`UL_NUM_REQ);

  arb_state_e state_r, state_n;
  logic [req_id_width_lp-1:0] grant_r, last_r, pick;
  logic req_any;

  assign req_any = |req_v_i;

  // Round robin, search starts just after the last winner
  always_comb
  begin
    int idx;
    pick = last_r;
    for (int i = `UL_NUM_REQ; i >= 1; i--)
    begin
      idx = (int'(last_r) + i) % `UL_NUM_REQ;
      if (req_v_i[idx])
        pick = idx[req_id_width_lp-1:0];
    end
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_arb_idle: if (req_any) state_n = e_arb_cmd;
      e_arb_cmd: if (cmd_ready_i) state_n = e_arb_resp;
      e_arb_resp: if (rsp_v_i & resp_ready_i[grant_r]) state_n = e_arb_idle;
      default: state_n = e_arb_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_arb_idle;
      grant_r <= '0;
      last_r <= req_id_width_lp'(`UL_NUM_REQ - 1);
    end
    else
    begin
      state_r <= state_n;
      if (state_r == e_arb_idle && req_any)
      begin
        grant_r <= pick;
        last_r <= pick;
      end
    end
  end

  // Granted command goes straight onto the shared bus
  assign cmd_v_o = (state_r == e_arb_cmd);
  assign cmd_op_o = req_op_i[grant_r];
  assign cmd_addr_o = req_addr_i[grant_r];
  assign cmd_data_o = req_data_i[grant_r];
  assign rsp_ready_o = (state_r == e_arb_resp) & resp_ready_i[grant_r];

  always_comb
  begin
    for (int k = 0; k < `UL_NUM_REQ; k++)
    begin
      req_ready_o[k] = cmd_v_o & cmd_ready_i & (grant_r == k);
      resp_v_o[k] = (state_r == e_arb_resp) & rsp_v_i & (grant_r == k);
      resp_data_o[k] = rsp_data_i;
    end
  end

endmodule

//--- rtl/uni_lite_cfg_slice.sv
`include "uni_lite_defines.svh"

module uni_lite_cfg_slice
  (input clk_i
  , input reset_i

  , input cmd_v_i
  , input uni_lite_pkg::mem_op_e cmd_op_i
  , input [`UL_PADDR_WIDTH-1:0] cmd_addr_i
  , input [`UL_DATA_WIDTH-1:0] cmd_data_i
  , output logic cmd_ready_o

  , output logic rsp_v_o
  , output logic [`UL_DATA_WIDTH-1:0] rsp_data_o
  , input rsp_ready_i

  , output logic freeze_o
  );

  import uni_lite_pkg::*;

  logic freeze_r;
  logic [`UL_DATA_WIDTH-1:0] scratch_r, rd_data;
  logic [7:0] offset;
  logic cmd_yumi;

  // One command at a time, busy while the response waits
  assign cmd_ready_o = ~rsp_v_o;
  assign cmd_yumi = cmd_v_i & cmd_ready_o;
  assign offset = cmd_addr_i[7:0];

  always_comb
  begin
    case (offset)
      `UL_CFG_FREEZE_ADDR: rd_data = `UL_DATA_WIDTH'(freeze_r);
      `UL_CFG_SCRATCH_ADDR: rd_data = scratch_r;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r <= 1'b1;
      scratch_r <= '0;
      rsp_v_o <= 1'b0;
    end
    else
    begin
      if (cmd_yumi)
        rsp_v_o <= 1'b1;
      else if (rsp_ready_i)
        rsp_v_o <= 1'b0;

      if (cmd_yumi && cmd_op_i == e_mem_wr)
      begin
        case (offset)
          `UL_CFG_FREEZE_ADDR: freeze_r <= cmd_data_i[0];
          `UL_CFG_SCRATCH_ADDR: scratch_r <= cmd_data_i;
          default: ;
        endcase
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (cmd_yumi)
      rsp_data_o <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
  end

  assign freeze_o = freeze_r;

endmodule

//--- rtl/uni_lite_clint_slice.sv
`include "uni_lite_defines.svh"

module uni_lite_clint_slice
  (input clk_i
  , input reset_i

  , input cmd_v_i
  , input uni_lite_pkg::mem_op_e cmd_op_i
  , input [`UL_PADDR_WIDTH-1:0] cmd_addr_i
  , input [`UL_DATA_WIDTH-1:0] cmd_data_i
  , output logic cmd_ready_o

  , output logic rsp_v_o
  , output logic [`UL_DATA_WIDTH-1:0] rsp_data_o
  , input rsp_ready_i

  , output logic timer_irq_o
  , output logic software_irq_o
  );

  import uni_lite_pkg::*;

  logic [`UL_DATA_WIDTH-1:0] mtime_r, mtimecmp_r, rd_data;
  logic msip_r;
  logic [7:0] offset;
  logic cmd_yumi;

  assign cmd_ready_o = ~rsp_v_o;
  assign cmd_yumi = cmd_v_i & cmd_ready_o;
  assign offset = cmd_addr_i[7:0];

  always_comb
  begin
    case (offset)
      `UL_CLINT_MSIP_ADDR: rd_data = `UL_DATA_WIDTH'(msip_r);
      `UL_CLINT_MTIMECMP_ADDR: rd_data = mtimecmp_r;
      `UL_CLINT_MTIME_ADDR: rd_data = mtime_r;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mtime_r <= '0;
      mtimecmp_r <= '1;
      msip_r <= 1'b0;
      timer_irq_o <= 1'b0;
      rsp_v_o <= 1'b0;
    end
    else
    begin
      // Free running timer, read only
      mtime_r <= mtime_r + 1'b1;
      timer_irq_o <= (mtime_r >= mtimecmp_r);

      if (cmd_yumi)
        rsp_v_o <= 1'b1;
      else if (rsp_ready_i)
        rsp_v_o <= 1'b0;

      if (cmd_yumi && cmd_op_i == e_mem_wr)
      begin
        case (offset)
          `UL_CLINT_MSIP_ADDR: msip_r <= cmd_data_i[0];
          `UL_CLINT_MTIMECMP_ADDR: mtimecmp_r <= cmd_data_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_yumi)
      rsp_data_o <= (cmd_op_i == e_mem_rd) ? rd_data : '0;
  end

  assign software_irq_o = msip_r;

endmodule

//--- rtl/uni_lite_defines.svh
`ifndef UNI_LITE_DEFINES_SVH
`define UNI_LITE_DEFINES_SVH

// Bus widths and requester count
`define UL_PADDR_WIDTH 32
`define UL_DATA_WIDTH 64
`define UL_NUM_REQ 2

// Memory map, addresses below the DRAM base are local
`define UL_DRAM_BASE 32'h8000_0000
`define UL_DEV_MSB 23
`define UL_DEV_LSB 20
`define UL_CFG_DEV 4'd1
`define UL_CLINT_DEV 4'd2

// Config slice register offsets
`define UL_CFG_FREEZE_ADDR 8'h00
`define UL_CFG_SCRATCH_ADDR 8'h08

// CLINT register offsets
`define UL_CLINT_MSIP_ADDR 8'h00
`define UL_CLINT_MTIMECMP_ADDR 8'h08
`define UL_CLINT_MTIME_ADDR 8'h10

`endif

//--- rtl/uni_lite_loopback.sv
`include "uni_lite_defines.svh"

module uni_lite_loopback
  (input clk_i
  , input reset_i

  , input cmd_v_i
  , input uni_lite_pkg::mem_op_e cmd_op_i
  , input [`UL_PADDR_WIDTH-1:0] cmd_addr_i
  , input [`UL_DATA_WIDTH-1:0] cmd_data_i
  , output logic cmd_ready_o

  , output logic rsp_v_o
  , output logic [`UL_DATA_WIDTH-1:0] rsp_data_o
  , input rsp_ready_i
  );

  // Unmapped space, any opcode, address or data gets a zero reply
  assign cmd_ready_o = ~rsp_v_o;
  assign rsp_data_o = '0;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_o <= 1'b0;
    else if (cmd_v_i & cmd_ready_o)
      rsp_v_o <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_o <= 1'b0;
  end

endmodule

//--- rtl/uni_lite_pkg.sv
package uni_lite_pkg;

  // Command opcode
  typedef enum logic
  {
    e_mem_rd = 1'b0
    , e_mem_wr = 1'b1
  } mem_op_e;

  // Decoded target, also the index into the router device arrays
  typedef enum logic [1:0]
  {
    e_dev_cfg = 2'd0
    , e_dev_clint = 2'd1
    , e_dev_loopback = 2'd2
    , e_dev_mem = 2'd3
  } dev_sel_e;

  // Arbiter transaction state
  typedef enum logic [1:0]
  {
    e_arb_idle = 2'd0
    , e_arb_cmd = 2'd1
    , e_arb_resp = 2'd2
  } arb_state_e;

endpackage

//--- rtl/uni_lite_router.sv
`include "uni_lite_defines.svh"

module uni_lite_router
  (input clk_i
  , input reset_i

  , input cmd_v_i
  , input uni_lite_pkg::mem_op_e cmd_op_i
  , input [`UL_PADDR_WIDTH-1:0] cmd_addr_i
  , input [`UL_DATA_WIDTH-1:0] cmd_data_i
  , output logic cmd_ready_o

  , output logic rsp_v_o
  , output logic [`UL_DATA_WIDTH-1:0] rsp_data_o
  , input rsp_ready_i

  , output logic [3:0] dev_cmd_v_o
  , output uni_lite_pkg::mem_op_e dev_op_o
  , output logic [`UL_PADDR_WIDTH-1:0] dev_addr_o
  , output logic [`UL_DATA_WIDTH-1:0] dev_data_o
  , input [3:0] dev_cmd_ready_i

  , input [3:0] dev_rsp_v_i
  , input [3:0][`UL_DATA_WIDTH-1:0] dev_rsp_data_i
  , output logic [3:0] dev_rsp_ready_o
  );

  import uni_lite_pkg::*;

  dev_sel_e dev_sel, sel_r;
  logic [`UL_DEV_MSB-`UL_DEV_LSB:0] dev_field;
  logic is_local;

  assign is_local = (cmd_addr_i < `UL_DRAM_BASE);
  assign dev_field = cmd_addr_i[`UL_DEV_MSB:`UL_DEV_LSB];

  always_comb
  begin
    if (!is_local)
      dev_sel = e_dev_mem;
    else if (dev_field == `UL_CFG_DEV)
      dev_sel = e_dev_cfg;
    else if (dev_field == `UL_CLINT_DEV)
      dev_sel = e_dev_clint;
    else
      dev_sel = e_dev_loopback;
  end

  // Remember the target so only its response is muxed back
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      sel_r <= e_dev_cfg;
    else if (cmd_v_i & cmd_ready_o)
      sel_r <= dev_sel;
  end

  assign dev_op_o = cmd_op_i;
  assign dev_addr_o = cmd_addr_i;
  assign dev_data_o = cmd_data_i;
  assign cmd_ready_o = dev_cmd_ready_i[dev_sel];

  assign rsp_v_o = dev_rsp_v_i[sel_r];
  assign rsp_data_o = dev_rsp_data_i[sel_r];

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      dev_cmd_v_o[i] = cmd_v_i & (dev_sel == dev_sel_e'(i));
      dev_rsp_ready_o[i] = rsp_ready_i & (sel_r == dev_sel_e'(i));
    end
  end

endmodule

//--- rtl/uni_lite_top.sv
`include "uni_lite_defines.svh"

module uni_lite_top
  (input clk_i
  , input reset_i

  , input [`UL_NUM_REQ-1:0] req_v_i
  , input uni_lite_pkg::mem_op_e [`UL_NUM_REQ-1:0] req_op_i
  , input [`UL_NUM_REQ-1:0][`UL_PADDR_WIDTH-1:0] req_addr_i
  , input [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] req_data_i
  , output logic [`UL_NUM_REQ-1:0] req_ready_o

  , output logic [`UL_NUM_REQ-1:0] resp_v_o
  , output logic [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] resp_data_o
  , input [`UL_NUM_REQ-1:0] resp_ready_i

  , output logic mem_cmd_v_o
  , output uni_lite_pkg::mem_op_e mem_cmd_op_o
  , output logic [`UL_PADDR_WIDTH-1:0] mem_cmd_addr_o
  , output logic [`UL_DATA_WIDTH-1:0] mem_cmd_data_o
  , input mem_cmd_ready_i

  , input mem_resp_v_i
  , input [`UL_DATA_WIDTH-1:0] mem_resp_data_i
  , output logic mem_resp_ready_o

  , output logic freeze_o
  , output logic timer_irq_o
  , output logic software_irq_o
  );

  logic cmd_v, cmd_ready, rsp_v, rsp_ready;
  uni_lite_pkg::mem_op_e cmd_op, dev_op;
  logic [`UL_PADDR_WIDTH-1:0] cmd_addr, dev_addr;
  logic [`UL_DATA_WIDTH-1:0] cmd_data, rsp_data, dev_data;

  logic [3:0] dev_cmd_v, dev_cmd_ready, dev_rsp_v, dev_rsp_ready;
  logic [3:0][`UL_DATA_WIDTH-1:0] dev_rsp_data;

  uni_lite_arbiter arbiter
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .req_v_i(req_v_i)
    , .req_op_i(req_op_i)
    , .req_addr_i(req_addr_i)
    , .req_data_i(req_data_i)
    , .req_ready_o(req_ready_o)
    , .resp_v_o(resp_v_o)
    , .resp_data_o(resp_data_o)
    , .resp_ready_i(resp_ready_i)
    , .cmd_v_o(cmd_v)
    , .cmd_op_o(cmd_op)
    , .cmd_addr_o(cmd_addr)
    , .cmd_data_o(cmd_data)
    , .cmd_ready_i(cmd_ready)
    , .rsp_v_i(rsp_v)
    , .rsp_data_i(rsp_data)
    , .rsp_ready_o(rsp_ready)
    );

  uni_lite_router router
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(cmd_v)
    , .cmd_op_i(cmd_op)
    , .cmd_addr_i(cmd_addr)
    , .cmd_data_i(cmd_data)
    , .cmd_ready_o(cmd_ready)
    , .rsp_v_o(rsp_v)
    , .rsp_data_o(rsp_data)
    , .rsp_ready_i(rsp_ready)
    , .dev_cmd_v_o(dev_cmd_v)
    , .dev_op_o(dev_op)
    , .dev_addr_o(dev_addr)
    , .dev_data_o(dev_data)
    , .dev_cmd_ready_i(dev_cmd_ready)
    , .dev_rsp_v_i(dev_rsp_v)
    , .dev_rsp_data_i(dev_rsp_data)
    , .dev_rsp_ready_o(dev_rsp_ready)
    );

  uni_lite_cfg_slice cfg
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(dev_cmd_v[uni_lite_pkg::e_dev_cfg])
    , .cmd_op_i(dev_op)
    , .cmd_addr_i(dev_addr)
    , .cmd_data_i(dev_data)
    , .cmd_ready_o(dev_cmd_ready[uni_lite_pkg::e_dev_cfg])
    , .rsp_v_o(dev_rsp_v[uni_lite_pkg::e_dev_cfg])
    , .rsp_data_o(dev_rsp_data[uni_lite_pkg::e_dev_cfg])
    , .rsp_ready_i(dev_rsp_ready[uni_lite_pkg::e_dev_cfg])
    , .freeze_o(freeze_o)
    );

  uni_lite_clint_slice clint
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(dev_cmd_v[uni_lite_pkg::e_dev_clint])
    , .cmd_op_i(dev_op)
    , .cmd_addr_i(dev_addr)
    , .cmd_data_i(dev_data)
    , .cmd_ready_o(dev_cmd_ready[uni_lite_pkg::e_dev_clint])
    , .rsp_v_o(dev_rsp_v[uni_lite_pkg::e_dev_clint])
    , .rsp_data_o(dev_rsp_data[uni_lite_pkg::e_dev_clint])
    , .rsp_ready_i(dev_rsp_ready[uni_lite_pkg::e_dev_clint])
    , .timer_irq_o(timer_irq_o)
    , .software_irq_o(software_irq_o)
    );

  uni_lite_loopback loopback
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .cmd_v_i(dev_cmd_v[uni_lite_pkg::e_dev_loopback])
    , .cmd_op_i(dev_op)
    , .cmd_addr_i(dev_addr)
    , .cmd_data_i(dev_data)
    , .cmd_ready_o(dev_cmd_ready[uni_lite_pkg::e_dev_loopback])
    , .rsp_v_o(dev_rsp_v[uni_lite_pkg::e_dev_loopback])
    , .rsp_data_o(dev_rsp_data[uni_lite_pkg::e_dev_loopback])
    , .rsp_ready_i(dev_rsp_ready[uni_lite_pkg::e_dev_loopback])
    );

  // Memory slot of the router is the external port
  assign mem_cmd_v_o = dev_cmd_v[uni_lite_pkg::e_dev_mem];
  assign mem_cmd_op_o = dev_op;
  assign mem_cmd_addr_o = dev_addr;
  assign mem_cmd_data_o = dev_data;
  assign dev_cmd_ready[uni_lite_pkg::e_dev_mem] = mem_cmd_ready_i;
  assign dev_rsp_v[uni_lite_pkg::e_dev_mem] = mem_resp_v_i;
  assign dev_rsp_data[uni_lite_pkg::e_dev_mem] = mem_resp_data_i;
  assign mem_resp_ready_o = dev_rsp_ready[uni_lite_pkg::e_dev_mem];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module uni_lite_tb -f uni_lite_top.f -Mdir obj_dir -o uni_lite_sim

./obj_dir/uni_lite_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

//--- test/uni_lite_asserts.sv
`include "uni_lite_defines.svh"

module uni_lite_asserts
  (input clk_i
  , input reset_i
  , input [`UL_NUM_REQ-1:0] req_ready_i
  , input [`UL_NUM_REQ-1:0] resp_v_i
  , input cmd_v_i
  , input uni_lite_pkg::mem_op_e cmd_op_i
  , input [`UL_PADDR_WIDTH-1:0] cmd_addr_i
  , input [`UL_DATA_WIDTH-1:0] cmd_data_i
  , input cmd_ready_i
  , input rsp_ready_i
  );

  // Command stays up with its payload until the router takes it
  cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_op_i) && $stable(cmd_addr_i)
      && $stable(cmd_data_i))
    else $error("cmd_v_o dropped or its payload changed before cmd_ready_i");

  // Only one transaction in flight
  resp_single: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(resp_v_i))
    else $error("more than one resp_v_o high at once");

  reset_quiet: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> !cmd_v_i && !rsp_ready_i && resp_v_i == '0
      && req_ready_i == '0)
    else $error("arbiter valid or ready output high during reset");

endmodule

bind uni_lite_arbiter uni_lite_asserts arbiter_asserts
  (.clk_i(clk_i)
  , .reset_i(reset_i)
  , .req_ready_i(req_ready_o)
  , .resp_v_i(resp_v_o)
  , .cmd_v_i(cmd_v_o)
  , .cmd_op_i(cmd_op_o)
  , .cmd_addr_i(cmd_addr_o)
  , .cmd_data_i(cmd_data_o)
  , .cmd_ready_i(cmd_ready_i)
  , .rsp_ready_i(rsp_ready_o)
  );

//--- test/uni_lite_checker.sv
`include "uni_lite_defines.svh"

module uni_lite_checker
  (input clk_i
  , input reset_i
  , input [`UL_NUM_REQ-1:0] req_v_i
  , input [`UL_NUM_REQ-1:0] req_ready_i
  , input [`UL_NUM_REQ-1:0] resp_v_i
  , input [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] resp_data_i
  , input [`UL_NUM_REQ-1:0] resp_ready_i
  , input freeze_i
  , input software_irq_i
  , input timer_irq_i
  , output int pending_o
  , output int data_errors_o
  , output int proto_errors_o
  );

  int exp_req_q[$];
  string exp_name_q[$];
  logic [`UL_DATA_WIDTH-1:0] exp_data_q[$];
  int pending = 0;
  int data_errors = 0;
  int proto_errors = 0;
  int last_grant = `UL_NUM_REQ - 1;

  assign pending_o = pending;
  assign data_errors_o = data_errors;
  assign proto_errors_o = proto_errors;

  task automatic expect_resp(input int k, input string name,
                             input logic [`UL_DATA_WIDTH-1:0] data);
    exp_req_q.push_back(k);
    exp_name_q.push_back(name);
    exp_data_q.push_back(data);
    pending++;
  endtask

  // Search starts one past the last winner
  function automatic int rr_winner(input logic [`UL_NUM_REQ-1:0] v, input int last);
    int idx;
    int winner;
    winner = -1;
    for (int i = 1; i <= `UL_NUM_REQ; i++)
    begin
      idx = (last + i) % `UL_NUM_REQ;
      if (v[idx] && winner < 0)
        winner = idx;
    end
    return winner;
  endfunction

  task automatic note_grant(input int k);
    int want;
    want = rr_winner(req_v_i, last_grant);
    if (want != k)
    begin
      $display("Error: requester %0d was granted while requester %0d had priority", k, want);
      proto_errors++;
    end
    last_grant = k;
  endtask

  task automatic take_resp(input int k, input logic [`UL_DATA_WIDTH-1:0] data);
    int idx;
    idx = -1;
    foreach (exp_req_q[i])
    begin
      if (idx < 0 && exp_req_q[i] == k)
        idx = i;
    end
    if (idx < 0)
    begin
      $display("Error: response on requester %0d with nothing outstanding", k);
      proto_errors++;
    end
    else
    begin
      if (data !== exp_data_q[idx])
      begin
        $display("Fail %s: expected %h, actual %h", exp_name_q[idx], exp_data_q[idx], data);
        data_errors++;
      end
      exp_req_q.delete(idx);
      exp_name_q.delete(idx);
      exp_data_q.delete(idx);
      pending--;
    end
  endtask

  // Timer level follows mtime, so it is awaited rather than sampled
  task automatic check_level(input string name, input string sig, input logic level);
    logic actual;
    if (sig == "timer_irq_o")
    begin
      while (timer_irq_i !== level)
        @(negedge clk_i);
      actual = timer_irq_i;
    end
    else if (sig == "freeze_o")
      actual = freeze_i;
    else
      actual = software_irq_i;
    if (actual !== level)
    begin
      $display("Fail %s: expected %s = %0b, actual %0b", name, sig, level, actual);
      data_errors++;
    end
  endtask

  // Mid cycle sampling, every handshake seen here completes at the next edge
  always @(negedge clk_i)
  begin
    if (reset_i)
      last_grant = `UL_NUM_REQ - 1;
    else
    begin
      for (int k = 0; k < `UL_NUM_REQ; k++)
      begin
        if (req_v_i[k] && req_ready_i[k])
          note_grant(k);
        if (resp_v_i[k] && resp_ready_i[k])
          take_resp(k, resp_data_i[k]);
      end
    end
  end

endmodule

//--- test/uni_lite_tb.sv
`include "uni_lite_defines.svh"

module uni_lite_tb;

  import uni_lite_pkg::*;

  localparam logic [`UL_PADDR_WIDTH-1:0] cfg_base_lp = 32'(`UL_CFG_DEV) << `UL_DEV_LSB;
  localparam logic [`UL_PADDR_WIDTH-1:0] clint_base_lp = 32'(`UL_CLINT_DEV) << `UL_DEV_LSB;
  localparam logic [`UL_PADDR_WIDTH-1:0] cfg_freeze_lp = cfg_base_lp + `UL_CFG_FREEZE_ADDR;
  localparam logic [`UL_PADDR_WIDTH-1:0] cfg_scratch_lp = cfg_base_lp + `UL_CFG_SCRATCH_ADDR;
  localparam logic [`UL_PADDR_WIDTH-1:0] msip_lp = clint_base_lp + `UL_CLINT_MSIP_ADDR;
  localparam logic [`UL_PADDR_WIDTH-1:0] mtimecmp_lp = clint_base_lp + `UL_CLINT_MTIMECMP_ADDR;
  // Device code 5 is not mapped
  localparam logic [`UL_PADDR_WIDTH-1:0] loop_base_lp = 32'h5 << `UL_DEV_LSB;
  localparam logic [`UL_DATA_WIDTH-1:0] scratch_val_lp = 64'h1234_5678_9abc_def0;
  localparam logic [`UL_DATA_WIDTH-1:0] mem_val_a_lp = 64'hcafe_f00d_0123_4567;
  localparam logic [`UL_DATA_WIDTH-1:0] mem_val_b_lp = 64'h0bad_beef_5a5a_a5a5;
  localparam logic [`UL_DATA_WIDTH-1:0] mem_val_c_lp = 64'h7777_0000_ffff_1111;

  logic clk, reset;
  logic [`UL_NUM_REQ-1:0] req_v, req_ready, resp_v, resp_ready;
  mem_op_e [`UL_NUM_REQ-1:0] req_op;
  logic [`UL_NUM_REQ-1:0][`UL_PADDR_WIDTH-1:0] req_addr;
  logic [`UL_NUM_REQ-1:0][`UL_DATA_WIDTH-1:0] req_data, resp_data;
  logic mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_ready;
  mem_op_e mem_cmd_op;
  logic [`UL_PADDR_WIDTH-1:0] mem_cmd_addr;
  logic [`UL_DATA_WIDTH-1:0] mem_cmd_data, mem_resp_data;
  logic freeze, timer_irq, software_irq;
  int pending, data_errs, proto_errs;

  logic [`UL_DATA_WIDTH-1:0] mem_model [logic [`UL_PADDR_WIDTH-1:0]];
  int seed;
  int cycle_cnt;
  int cycle_limit = 0;
  string current_test = "reset";

  // Stimulus table with one column per queue
  string names_q[$];
  int reqs_q[$];
  mem_op_e ops_q[$];
  logic [`UL_PADDR_WIDTH-1:0] addrs_q[$];
  logic [`UL_DATA_WIDTH-1:0] wdata_q[$];
  logic [`UL_DATA_WIDTH-1:0] exp_q[$];
  bit pair_q[$];
  string sig_q[$];
  logic lvl_q[$];

  uni_lite_top uni_lite_top_inst
    (.clk_i(clk)
    , .reset_i(reset)
    , .req_v_i(req_v)
    , .req_op_i(req_op)
    , .req_addr_i(req_addr)
    , .req_data_i(req_data)
    , .req_ready_o(req_ready)
    , .resp_v_o(resp_v)
    , .resp_data_o(resp_data)
    , .resp_ready_i(resp_ready)
    , .mem_cmd_v_o(mem_cmd_v)
    , .mem_cmd_op_o(mem_cmd_op)
    , .mem_cmd_addr_o(mem_cmd_addr)
    , .mem_cmd_data_o(mem_cmd_data)
    , .mem_cmd_ready_i(mem_cmd_ready)
    , .mem_resp_v_i(mem_resp_v)
    , .mem_resp_data_i(mem_resp_data)
    , .mem_resp_ready_o(mem_resp_ready)
    , .freeze_o(freeze)
    , .timer_irq_o(timer_irq)
    , .software_irq_o(software_irq)
    );

  uni_lite_checker resp_checker
    (.clk_i(clk)
    , .reset_i(reset)
    , .req_v_i(req_v)
    , .req_ready_i(req_ready)
    , .resp_v_i(resp_v)
    , .resp_data_i(resp_data)
    , .resp_ready_i(resp_ready)
    , .freeze_i(freeze)
    , .software_irq_i(software_irq)
    , .timer_irq_i(timer_irq)
    , .pending_o(pending)
    , .data_errors_o(data_errs)
    , .proto_errors_o(proto_errs)
    );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  task automatic add_entry(input string name, input int k, input mem_op_e op,
                           input logic [`UL_PADDR_WIDTH-1:0] addr,
                           input logic [`UL_DATA_WIDTH-1:0] wdata,
                           input logic [`UL_DATA_WIDTH-1:0] exp, input bit pair,
                           input string sig = "", input logic lvl = 1'b0);
    names_q.push_back(name);
    reqs_q.push_back(k);
    ops_q.push_back(op);
    addrs_q.push_back(addr);
    wdata_q.push_back(wdata);
    exp_q.push_back(exp);
    pair_q.push_back(pair);
    sig_q.push_back(sig);
    lvl_q.push_back(lvl);
  endtask

  // Called at posedge + 2 and returns at posedge + 2 after the command beat
  task automatic issue(input int k, input mem_op_e op,
                       input logic [`UL_PADDR_WIDTH-1:0] addr,
                       input logic [`UL_DATA_WIDTH-1:0] data);
    req_v[k] = 1'b1;
    req_op[k] = op;
    req_addr[k] = addr;
    req_data[k] = data;
    do
      @(negedge clk);
    while (!req_ready[k]);
    @(posedge clk);
    #2;
    req_v[k] = 1'b0;
  endtask

  // Memory model with 1 to 4 cycles from command beat to response valid
  initial
  begin
    int lat;
    int busy;
    logic [`UL_PADDR_WIDTH-1:0] addr;
    logic [`UL_DATA_WIDTH-1:0] rdata;
    seed = 23;
    mem_cmd_ready = 1'b0;
    mem_resp_v = 1'b0;
    mem_resp_data = '0;
    @(posedge clk);
    while (reset)
      @(posedge clk);
    #2;
    mem_cmd_ready = 1'b1;
    forever
    begin
      do
        @(negedge clk);
      while (!(mem_cmd_v && mem_cmd_ready));
      addr = mem_cmd_addr;
      if (mem_cmd_op == e_mem_wr)
      begin
        mem_model[addr] = mem_cmd_data;
        rdata = '0;
      end
      else if (mem_model.exists(addr))
        rdata = mem_model[addr];
      else
        rdata = 64'(addr);
      lat = 1 + int'($unsigned($random(seed)) % 4);
      @(posedge clk);
      #2;
      mem_cmd_ready = 1'b0;
      repeat (lat - 1)
      begin
        @(posedge clk);
        #2;
      end
      mem_resp_v = 1'b1;
      mem_resp_data = rdata;
      do
        @(negedge clk);
      while (!mem_resp_ready);
      @(posedge clk);
      #2;
      mem_resp_v = 1'b0;
      // Two or three busy cycles before the next command is taken
      busy = 2 + int'($unsigned($random(seed)) % 2);
      repeat (busy)
      begin
        @(posedge clk);
        #2;
      end
      mem_cmd_ready = 1'b1;
    end
  end

  initial
  begin
    wait (cycle_limit > 0);
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run passed %0d cycles while in test %s", cycle_limit, current_test);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    int i;
    int n;
    reset = 1'b1;
    req_v = '0;
    req_addr = '0;
    req_data = '0;
    resp_ready = '0;
    for (int k = 0; k < `UL_NUM_REQ; k++)
      req_op[k] = e_mem_rd;

    add_entry("cfg_freeze_reset", 0, e_mem_rd, cfg_freeze_lp, '0, 64'h1, 1, "freeze_o", 1);
    add_entry("mem_unwritten", 1, e_mem_rd, 32'h8000_0040, '0, 64'h8000_0040, 0);
    add_entry("cfg_scratch_wr", 0, e_mem_wr, cfg_scratch_lp, scratch_val_lp, '0, 0);
    add_entry("cfg_scratch_rd", 1, e_mem_rd, cfg_scratch_lp, '0, scratch_val_lp, 0);
    add_entry("cfg_freeze_clr", 0, e_mem_wr, cfg_freeze_lp, '0, '0, 0, "freeze_o", 0);
    add_entry("cfg_freeze_rd", 1, e_mem_rd, cfg_freeze_lp, '0, '0, 0);
    add_entry("msip_set", 0, e_mem_wr, msip_lp, 64'h1, '0, 0, "software_irq_o", 1);
    add_entry("msip_rd", 1, e_mem_rd, msip_lp, '0, 64'h1, 0);
    add_entry("msip_clr", 0, e_mem_wr, msip_lp, '0, '0, 0, "software_irq_o", 0);
    add_entry("mtimecmp_small", 1, e_mem_wr, mtimecmp_lp, 64'h80, '0, 0, "timer_irq_o", 1);
    add_entry("mtimecmp_rd", 0, e_mem_rd, mtimecmp_lp, '0, 64'h80, 0);
    add_entry("mtimecmp_max", 1, e_mem_wr, mtimecmp_lp, '1, '0, 0, "timer_irq_o", 0);
    add_entry("loopback_rd", 0, e_mem_rd, loop_base_lp + 32'h10, '0, '0, 0);
    add_entry("loopback_wr", 1, e_mem_wr, loop_base_lp + 32'h18, 64'hdead, '0, 0);
    add_entry("mem_wr", 0, e_mem_wr, 32'h8000_1000, mem_val_a_lp, '0, 0);
    add_entry("mem_rd", 1, e_mem_rd, 32'h8000_1000, '0, mem_val_a_lp, 0);
    add_entry("pair_mem_wr", 1, e_mem_wr, 32'h8000_2000, mem_val_b_lp, '0, 1);
    add_entry("pair_mem_rd", 0, e_mem_rd, 32'h8000_1000, '0, mem_val_a_lp, 0);
    add_entry("mem_rd_back", 0, e_mem_rd, 32'h8000_2000, '0, mem_val_b_lp, 0);
    add_entry("pair2_mem_wr", 0, e_mem_wr, 32'h8000_2008, mem_val_c_lp, '0, 1);
    add_entry("pair2_cfg_rd", 1, e_mem_rd, cfg_scratch_lp, '0, scratch_val_lp, 0);
    add_entry("mem_rd_back2", 1, e_mem_rd, 32'h8000_2008, '0, mem_val_c_lp, 0);
    cycle_limit = 40 * names_q.size() + 200;

    repeat (10)
      @(posedge clk);
    #2;
    reset = 1'b0;
    resp_ready = '1;

    i = 0;
    while (i < names_q.size())
    begin
      current_test = names_q[i];
      n = (pair_q[i] && i + 1 < names_q.size()) ? 2 : 1;
      for (int j = i; j < i + n; j++)
        resp_checker.expect_resp(reqs_q[j], names_q[j], exp_q[j]);
      if (n == 2)
      begin
        fork
          issue(reqs_q[i], ops_q[i], addrs_q[i], wdata_q[i]);
          issue(reqs_q[i + 1], ops_q[i + 1], addrs_q[i + 1], wdata_q[i + 1]);
        join
      end
      else
        issue(reqs_q[i], ops_q[i], addrs_q[i], wdata_q[i]);
      do
        @(posedge clk);
      while (pending != 0);
      #2;
      for (int j = i; j < i + n; j++)
      begin
        if (sig_q[j] != "")
          resp_checker.check_level(names_q[j], sig_q[j], lvl_q[j]);
      end
      @(posedge clk);
      #2;
      i += n;
    end

    $display("Errors: %0d data mismatches, %0d protocol errors", data_errs, proto_errs);
    if (data_errs + proto_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- uni_lite_top.f
+incdir+rtl
rtl/uni_lite_pkg.sv
rtl/uni_lite_arbiter.sv
rtl/uni_lite_router.sv
rtl/uni_lite_cfg_slice.sv
rtl/uni_lite_clint_slice.sv
rtl/uni_lite_loopback.sv
rtl/uni_lite_top.sv
test/uni_lite_asserts.sv
test/uni_lite_checker.sv
test/uni_lite_tb.sv
